/* vlog.f */
source/t07_mmio_pkg.sv
source/t07_mem_handler.sv
source/t07_mmio.sv
source/t07_data_mem.sv
source/t07_ext_regs.sv
source/t07_tft_port.sv
source/t07_mmio_top.sv
verif/t07_mmio_monitor.sv
verif/t07_mmio_chk.sv
verif/t07_mmio_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mmio testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module t07_mmio_tb -o t07_mmio_sim
# error limit raised so assertion failures still reach the testbench summary
out=$(./obj_dir/t07_mmio_sim +verilator+error+limit+100) || true
echo "$out"
echo "$out" | grep -qF '** PASS **'

/* verif/t07_mmio_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_mmio_tb;
    import t07_mmio_pkg::*;

    localparam int WAIT_CYCLES = 3;
    localparam int TFT_CYCLES  = 2;
    localparam int DMEM_AW     = 10;   // data words from 1024 up alias onto fetch words
    localparam int TIMEOUT     = 100;  // cycles allowed per wait

    typedef struct {
        rwi_e        op;     // RWI_IDLE here means an external register load alone
        logic [31:0] addr;
        logic [31:0] wdata;  // store data, or register value for a load
        logic [31:0] exp;
        logic        chk;    // compare rdata
        logic        load;   // external load of register addr[4:0] in the cycle after the strobe
    } entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_valid;
    rwi_e        cmd_op;
    logic [31:0] cmd_addr, cmd_wdata;
    logic        cmd_idle, done, pix_valid;
    logic [31:0] rdata, pix_addr, pix_data;
    logic        reg_load_en;
    logic [4:0]  reg_load_addr;
    logic [31:0] reg_load_data;
    logic [31:0] exp_rdata;   // handed to the monitor with each command
    logic        exp_check;
    int          tests, errors, pix_left;
    int          stalls = 0;  // waits that ran out
    integer      seed = 32'h8c521b63;
    logic [31:0] r [6];       // random store data
    entry_t      tbl [$];

    always #10 clk = ~clk;

    t07_mmio_top #(
        .WAIT_CYCLES(WAIT_CYCLES), .TFT_CYCLES(TFT_CYCLES), .DMEM_AW(DMEM_AW)
    ) t07_mmio_top_inst (.*);

    t07_mmio_monitor #(.DMEM_AW(DMEM_AW)) u_mon (.*);

    task automatic apply_entry(input entry_t e, input int i);
        int t;
        t = 0;
        while (!cmd_idle && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!cmd_idle) begin
            $display("entry %0d: handler never returned to idle", i);
            stalls++;
            return;
        end
        reg_load_en   = (e.op == RWI_IDLE);
        reg_load_addr = e.addr[4:0];
        reg_load_data = e.wdata;
        cmd_valid     = (e.op != RWI_IDLE);
        cmd_op        = e.op;
        cmd_addr      = e.addr;
        cmd_wdata     = e.wdata;
        exp_rdata     = e.exp;
        exp_check     = e.chk;
        @(posedge clk);
        #1;
        cmd_valid   = 1'b0;    // one cycle strobes
        reg_load_en = e.load;  // load lands while the handler is still issuing
        if (e.op == RWI_IDLE) return;
        t = 0;
        while (!done && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            reg_load_en = 1'b0;
            t++;
        end
        if (!done) begin
            $display("entry %0d: timed out waiting for done", i);
            stalls++;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = RWI_IDLE;
        cmd_addr      = '0;
        cmd_wdata     = '0;
        reg_load_en   = 1'b0;
        reg_load_addr = '0;
        reg_load_data = '0;
        exp_rdata     = '0;
        exp_check     = 1'b0;
        foreach (r[k]) r[k] = $random(seed);

        tbl.push_back(entry_t'{RWI_WRITE, 32'd1100, r[0], 32'd0, 1'b1, 1'b0});  // word 76
        tbl.push_back(entry_t'{RWI_READ,  32'd1100, 32'd0, r[0], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_WRITE, 32'd1200, r[1], 32'd0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_READ,  32'd1300, 32'd0, 32'd0, 1'b0, 1'b0});  // never written
        tbl.push_back(entry_t'{RWI_READ,  32'd1100, 32'd0, r[0], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_READ,  32'd1200, 32'd0, r[1], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_WRITE, 32'd1124, r[2], 32'd0, 1'b1, 1'b0});  // word 100
        tbl.push_back(entry_t'{RWI_FETCH, 32'd76,   32'd0, r[0], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_FETCH, 32'd100,  32'd0, r[2], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_FETCH, 32'd1500, 32'd0, NO_INSTR, 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_FETCH, 32'd1050, 32'd0, NO_INSTR, 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_IDLE,  32'd5,    r[3], 32'd0, 1'b0, 1'b0});  // load reg 5
        tbl.push_back(entry_t'{RWI_READ,  32'd1029, 32'd0, r[3], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_WRITE, 32'd1029, r[4], 32'd0, 1'b1, 1'b0});  // no target
        tbl.push_back(entry_t'{RWI_READ,  32'd1029, 32'd0, r[3], 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_READ,  32'd1042, r[4], r[4], 1'b1, 1'b1});   // reg 18, cs hold
        tbl.push_back(entry_t'{RWI_WRITE, 32'd1800, r[5], 32'd0, 1'b1, 1'b0});  // one pixel
        tbl.push_back(entry_t'{RWI_READ,  32'd1900, 32'd0, 32'd0, 1'b1, 1'b0});
        tbl.push_back(entry_t'{RWI_READ,  32'd512,  32'd0, 32'd0, 1'b1, 1'b0});

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (tbl[k]) apply_entry(tbl[k], k);
        @(posedge clk);
        #1;
        if (pix_left != 0) begin
            $display("%0d tft stores never produced a pixel write", pix_left);
            stalls++;
        end
        $display("tests %0d, errors %0d, stalled waits %0d, assertion failures %0d",
                 tests, errors, stalls, t07_mmio_top_inst.u_chk.fail_cnt);
        if (errors == 0 && stalls == 0 && t07_mmio_top_inst.u_chk.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/t07_mmio_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// sits on the top, where router strobes and handler outputs share one clock
module t07_mmio_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               cmd_idle,
    input logic               done,
    input t07_mmio_pkg::rwi_e rwi,
    input logic               reg_rd,
    input logic               tft_wr,
    input logic               wb_read,
    input logic               wb_write
);
    int n_target = 0;  // failures per property
    int n_done   = 0;
    int n_rwi    = 0;
    int fail_cnt;

    assign fail_cnt = n_target + n_done + n_rwi;

    // router drives one target at most
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({reg_rd, tft_wr, wb_read, wb_write}))
        else begin
            $error("router strobes more than one target");
            n_target++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done high for two cycles in a row");
            n_done++;
        end

    // request held from issue until the handler goes idle again
    a_rwi_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_idle |=> (cmd_idle || $stable(rwi)))
        else begin
            $error("rwi changed while the handler was waiting");
            n_rwi++;
        end

endmodule

bind t07_mmio_top t07_mmio_chk u_chk (
    .clk, .rst_n, .cmd_idle, .done, .rwi, .reg_rd, .tft_wr, .wb_read, .wb_write
);

`default_nettype wire

/* verif/t07_mmio_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_mmio_monitor #(
    parameter int DMEM_AW = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  t07_mmio_pkg::rwi_e cmd_op,
    input  logic [31:0]        cmd_addr,
    input  logic [31:0]        cmd_wdata,
    input  logic               cmd_idle,
    input  logic               done,
    input  logic [31:0]        rdata,
    input  logic               reg_load_en,
    input  logic [4:0]         reg_load_addr,
    input  logic [31:0]        reg_load_data,
    input  logic               pix_valid,
    input  logic [31:0]        pix_addr,
    input  logic [31:0]        pix_data,
    input  logic [31:0]        exp_rdata,  // table value for the command being issued
    input  logic               exp_check,
    output int                 tests,
    output int                 errors,
    output int                 pix_left    // tft stores still owed a pixel
);
    import t07_mmio_pkg::*;

    logic [31:0] mem_m [2**DMEM_AW];  // word index is the low address bits
    logic [31:0] reg_m [32];
    logic [63:0] pix_q [$];           // {addr, data} per tft store
    rwi_e        op_q;
    logic [31:0] addr_q, tbl_q, model;
    logic        chk_q;
    logic        rst_seen;
    int          lat;                 // edges since the command was taken

    // address map reference, regions as documented for the cpu
    function automatic logic [31:0] model_rdata(input rwi_e op, input logic [31:0] a);
        if (op == RWI_FETCH) return (a <= REG_LO) ? mem_m[a[DMEM_AW-1:0]] : NO_INSTR;
        if (op != RWI_READ) return '0;  // stores give zero
        if (a > REG_LO && a <= REG_HI) return reg_m[a[4:0]];
        if (a > REG_HI && a <= DMEM_HI) return mem_m[a[DMEM_AW-1:0]];
        return '0;                      // fetch space or tft, nothing answers
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            tests    = 0;
            errors   = 0;
            pix_left = 0;
            rst_seen = 1'b0;
            pix_q.delete();
            for (int i = 0; i < 32; i++) reg_m[i] = '0;
        end else begin
            if (!rst_seen) begin  // first edge out of reset
                rst_seen = 1'b1;
                tests++;
                if (!cmd_idle || done || pix_valid) begin
                    errors++;
                    $display("FAIL reset cmd_idle 0x%h done 0x%h pix_valid 0x%h",
                             cmd_idle, done, pix_valid);
                end else begin
                    $display("test %0d reset state ok", tests);
                end
            end
            if (reg_load_en) reg_m[reg_load_addr] = reg_load_data;
            lat++;
            if (done) begin
                tests++;
                model = model_rdata(op_q, addr_q);
                if (lat < 3) begin
                    errors++;
                    $display("test %0d: done came %0d cycles after the command, too early",
                             tests, lat);
                end else if (!chk_q) begin
                    $display("test %0d %s 0x%h rdata 0x%h not compared",
                             tests, op_q.name(), addr_q, rdata);
                end else if (rdata !== model || rdata !== tbl_q) begin
                    errors++;
                    $display("FAIL test %0d rdata 0x%h expected 0x%h table 0x%h",
                             tests, rdata, model, tbl_q);
                end else begin
                    $display("test %0d %s 0x%h rdata 0x%h ok",
                             tests, op_q.name(), addr_q, rdata);
                end
            end
            if (pix_valid) begin
                tests++;
                if (pix_q.size() == 0) begin
                    errors++;
                    $display("test %0d: pixel write with no tft store behind it", tests);
                end else if ({pix_addr, pix_data} !== pix_q[0]) begin
                    errors++;
                    $display("FAIL test %0d pix_addr 0x%h pix_data 0x%h expected 0x%h 0x%h",
                             tests, pix_addr, pix_data, pix_q[0][63:32], pix_q[0][31:0]);
                end else begin
                    $display("test %0d pixel 0x%h data 0x%h ok", tests, pix_addr, pix_data);
                end
                if (pix_q.size() != 0) void'(pix_q.pop_front());
            end
            if (cmd_valid && cmd_idle) begin
                op_q   = cmd_op;
                addr_q = cmd_addr;
                tbl_q  = exp_rdata;
                chk_q  = exp_check;
                lat    = 0;
                if (cmd_op == RWI_WRITE && cmd_addr > REG_HI && cmd_addr <= DMEM_HI)
                    mem_m[cmd_addr[DMEM_AW-1:0]] = cmd_wdata;
                if (cmd_op == RWI_WRITE && cmd_addr > DMEM_HI && cmd_addr < TFT_HI)
                    pix_q.push_back({cmd_addr, cmd_wdata});
            end
            pix_left = pix_q.size();
        end
    end

endmodule

`default_nettype wire

/* source/t07_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_mmio_top #(
    parameter int WAIT_CYCLES = 3,
    parameter int TFT_CYCLES  = 2,
    parameter int DMEM_AW     = 11
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  t07_mmio_pkg::rwi_e cmd_op,
    input  logic [31:0]        cmd_addr,
    input  logic [31:0]        cmd_wdata,
    output logic               cmd_idle,
    output logic               done,
    output logic [31:0]        rdata,
    input  logic               reg_load_en,
    input  logic [4:0]         reg_load_addr,
    input  logic [31:0]        reg_load_data,
    output logic               pix_valid,
    output logic [31:0]        pix_addr,
    output logic [31:0]        pix_data
);
    import t07_mmio_pkg::*;

    // handler side
    rwi_e        rwi;
    logic [31:0] addr, mem_data, load_data, instr;
    logic        busy;
    // memory side
    logic        wb_read, wb_write, wb_busy;
    logic [31:0] wb_addr, wb_wdata, ext_data;
    // register and tft side
    logic        reg_rd, reg_ack, reg_cs, tft_wr, tft_ack;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data, tft_addr, tft_data;

    t07_mem_handler u_handler (
        .clk, .rst_n, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata,
        .busy, .load_data, .instr, .cmd_idle, .done, .rdata,
        .rwi, .addr, .mem_data
    );

    t07_mmio u_mmio (
        .rwi, .addr, .mem_data, .ext_data, .wb_busy, .reg_data, .reg_ack, .reg_cs,
        .tft_ack, .busy, .load_data, .instr, .reg_rd, .reg_addr, .tft_wr, .tft_addr,
        .tft_data, .wb_read, .wb_write, .wb_addr, .wb_wdata
    );

    t07_data_mem #(.WAIT_CYCLES(WAIT_CYCLES), .DMEM_AW(DMEM_AW)) u_dmem (
        .clk, .rst_n, .wb_read, .wb_write, .wb_addr, .wb_wdata, .ext_data, .wb_busy
    );

    t07_ext_regs u_regs (
        .clk, .rst_n, .reg_rd, .reg_addr, .reg_load_en, .reg_load_addr, .reg_load_data,
        .reg_data, .reg_ack, .reg_cs
    );

    t07_tft_port #(.TFT_CYCLES(TFT_CYCLES)) u_tft (
        .clk, .rst_n, .tft_wr, .tft_addr, .tft_data, .tft_ack, .pix_valid, .pix_addr,
        .pix_data
    );

endmodule

`default_nettype wire

/* source/t07_tft_port.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_tft_port #(
    parameter int TFT_CYCLES = 2  // ack length per write
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tft_wr,
    input  logic [31:0] tft_addr,
    input  logic [31:0] tft_data,
    output logic        tft_ack,
    output logic        pix_valid,
    output logic [31:0] pix_addr,
    output logic [31:0] pix_data
);
    localparam int CW = $clog2(TFT_CYCLES + 1);

    logic          started;  // current write already taken
    logic [CW-1:0] ack_cnt;  // remaining ack cycles after the first
    logic          first;

    assign first   = tft_wr && !started;
    assign tft_ack = first || (ack_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started   <= 1'b0;
            ack_cnt   <= '0;
            pix_valid <= 1'b0;
        end else begin
            started   <= tft_wr;  // clears once the write is removed
            pix_valid <= first;   // one pulse per write
            if (first) ack_cnt <= CW'(TFT_CYCLES - 1);
            else if (ack_cnt != '0) ack_cnt <= ack_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (first) begin
            pix_addr <= tft_addr;
            pix_data <= tft_data;
        end
    end

endmodule

`default_nettype wire

/* source/t07_ext_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_ext_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        reg_rd,         // cpu read level
    input  logic [4:0]  reg_addr,
    input  logic        reg_load_en,    // external write port
    input  logic [4:0]  reg_load_addr,
    input  logic [31:0] reg_load_data,
    output logic [31:0] reg_data,
    output logic        reg_ack,
    output logic        reg_cs
);
    logic [31:0] regs [32];
    logic        load_q;  // load seen last cycle
    logic        rd_q;    // read already running

    assign reg_cs   = !(reg_load_en || load_q);  // low during load and the cycle after
    assign reg_ack  = reg_rd && !rd_q;           // first read cycle only
    assign reg_data = regs[reg_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            rd_q   <= 1'b0;
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else begin
            load_q <= reg_load_en;
            rd_q   <= reg_rd;
            if (reg_load_en) regs[reg_load_addr] <= reg_load_data;
        end
    end

endmodule

`default_nettype wire

/* source/t07_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_data_mem #(
    parameter int WAIT_CYCLES = 3,   // busy time per access
    parameter int DMEM_AW     = 11   // word index bits
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_read,
    input  logic        wb_write,
    input  logic [31:0] wb_addr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] ext_data,
    output logic        wb_busy
);
    import t07_mmio_pkg::*;

    localparam int CW = $clog2(WAIT_CYCLES + 1);

    logic [31:0]        mem [2**DMEM_AW];
    logic [CW-1:0]      wait_cnt;  // cycles spent in the current access
    logic               served;    // access finished, waiting for request to drop
    logic               req;
    logic               last;      // final busy cycle
    logic [DMEM_AW-1:0] idx;

    assign idx     = wb_addr[DMEM_AW-1:0];
    assign req     = (wb_read || wb_write) && (wb_addr[31:24] == EXT_PAGE);  // own page only
    assign wb_busy = req && !served;
    assign last    = wb_busy && (wait_cnt == CW'(WAIT_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            served   <= 1'b0;
        end else if (!req) begin
            wait_cnt <= '0;   // rearm for next request
            served   <= 1'b0;
        end else if (last) begin
            wait_cnt <= '0;
            served   <= 1'b1;
        end else if (wb_busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // write commits and read data lands as busy falls
    always_ff @(posedge clk) begin
        if (last && wb_write) mem[idx] <= wb_wdata;
        if (last && wb_read) ext_data <= mem[idx];
    end

endmodule

`default_nettype wire

/* source/t07_mmio.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_mmio (
    input  t07_mmio_pkg::rwi_e rwi,
    input  logic [31:0]        addr,
    input  logic [31:0]        mem_data,   // store data from handler
    input  logic [31:0]        ext_data,   // memory read data
    input  logic               wb_busy,
    input  logic [31:0]        reg_data,
    input  logic               reg_ack,
    input  logic               reg_cs,     // low while a register is being loaded
    input  logic               tft_ack,
    output logic               busy,
    output logic [31:0]        load_data,
    output logic [31:0]        instr,
    output logic               reg_rd,
    output logic [4:0]         reg_addr,
    output logic               tft_wr,
    output logic [31:0]        tft_addr,
    output logic [31:0]        tft_data,
    output logic               wb_read,
    output logic               wb_write,
    output logic [31:0]        wb_addr,
    output logic [31:0]        wb_wdata
);
    import t07_mmio_pkg::*;

    logic in_fetch, in_reg, in_dmem, in_tft;   // address region
    logic hit_fetch, hit_reg, hit_dmem, hit_tft;  // region and kind agree

    assign in_fetch = (addr <= REG_LO);
    assign in_reg   = (addr > REG_LO) && (addr <= REG_HI);
    assign in_dmem  = (addr > REG_HI) && (addr <= DMEM_HI);
    assign in_tft   = (addr > DMEM_HI) && (addr < TFT_HI);

    assign hit_fetch = (rwi == RWI_FETCH) && in_fetch;
    assign hit_reg   = (rwi == RWI_READ) && in_reg;   // registers are read only
    assign hit_dmem  = ((rwi == RWI_READ) || (rwi == RWI_WRITE)) && in_dmem;
    assign hit_tft   = (rwi == RWI_WRITE) && in_tft;  // tft is write only

    // busy merge, first match wins
    always_comb begin
        if (tft_ack || wb_busy) busy = 1'b1;
        else if (hit_reg && reg_cs) busy = reg_ack;
        else if (hit_reg) busy = 1'b1;  // hold until chip select returns
        else busy = 1'b0;
    end

    always_comb begin
        load_data = '0;
        instr     = NO_INSTR;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        tft_wr    = 1'b0;
        tft_addr  = '0;
        tft_data  = '0;
        wb_read   = 1'b0;
        wb_write  = 1'b0;
        wb_addr   = '0;
        wb_wdata  = '0;

        if (hit_fetch) begin
            wb_read = 1'b1;
            wb_addr = {EXT_PAGE, addr[23:0]};  // memory page
            instr   = ext_data;
        end else if (hit_dmem) begin
            wb_addr = {EXT_PAGE, addr[23:0]};
            if (rwi == RWI_WRITE) begin
                wb_write = 1'b1;
                wb_wdata = mem_data;
            end else begin
                wb_read   = 1'b1;
                load_data = ext_data;
            end
        end else if (hit_reg && reg_cs) begin
            reg_rd    = 1'b1;
            reg_addr  = addr[4:0];   // low bits pick the register
            load_data = reg_data;
        end else if (hit_tft) begin
            tft_wr   = 1'b1;
            tft_addr = addr;
            tft_data = mem_data;
        end
    end

endmodule

`default_nettype wire

/* source/t07_mem_handler.sv */
`timescale 1ns/1ps
`default_nettype none

module t07_mem_handler (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,   // one cycle strobe, only seen while idle
    input  t07_mmio_pkg::rwi_e cmd_op,
    input  logic [31:0]        cmd_addr,
    input  logic [31:0]        cmd_wdata,
    input  logic               busy,        // from router
    input  logic [31:0]        load_data,
    input  logic [31:0]        instr,
    output logic               cmd_idle,
    output logic               done,
    output logic [31:0]        rdata,
    output t07_mmio_pkg::rwi_e rwi,
    output logic [31:0]        addr,
    output logic [31:0]        mem_data
);
    import t07_mmio_pkg::*;

    hstate_e     state;
    logic [31:0] result;  // value picked by request kind
    logic        finish;  // busy seen low while waiting

    assign cmd_idle = (state == ST_IDLE);
    assign finish   = (state == ST_WAIT) && !busy;

    // fetch returns the instruction path, load the data path, store gives zero
    always_comb begin
        unique case (rwi)
            RWI_FETCH: result = instr;
            RWI_READ:  result = load_data;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            rwi   <= RWI_IDLE;
            addr  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;  // single cycle pulse
            unique case (state)
                ST_IDLE: if (cmd_valid) begin
                    state <= ST_ISSUE;
                    rwi   <= cmd_op;    // request goes out next cycle
                    addr  <= cmd_addr;
                end
                ST_ISSUE: state <= ST_WAIT;  // one full cycle before busy counts
                ST_WAIT: if (!busy) begin
                    state <= ST_IDLE;
                    rwi   <= RWI_IDLE;  // drop request with done
                    done  <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_idle && cmd_valid) mem_data <= cmd_wdata;
        if (finish) rdata <= result;
    end

endmodule

`default_nettype wire

/* source/t07_mmio_pkg.sv */
`default_nettype none

package t07_mmio_pkg;

    // request kind driven by the cpu side handler
    typedef enum logic [1:0] {
        RWI_IDLE  = 2'b00,  // nothing on the bus
        RWI_WRITE = 2'b01,  // store
        RWI_READ  = 2'b10,  // load
        RWI_FETCH = 2'b11   // instruction fetch
    } rwi_e;

    // handler fsm states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_ISSUE = 2'b01,
        ST_WAIT  = 2'b10
    } hstate_e;

    // address map, each region starts just above the previous bound
    localparam logic [31:0] REG_LO  = 32'd1024;  // top of fetch space
    localparam logic [31:0] REG_HI  = 32'd1056;  // top of external registers
    localparam logic [31:0] DMEM_HI = 32'd1792;  // top of data memory
    localparam logic [31:0] TFT_HI  = 32'd2048;  // tft region ends below this

    localparam logic [7:0]  EXT_PAGE = 8'h33;          // memory page byte
    localparam logic [31:0] NO_INSTR = 32'hDEADBEEF;   // filler when no fetch routed

endpackage

`default_nettype wire
